/* mips_system.f */
+incdir+common
common/mips_pkg.sv
hw/cpu/cpu_control.sv
hw/cpu/pc_counter.sv
hw/cpu/reg_file.sv
hw/cpu/alu_exec.sv
hw/cpu/cpu_core.sv
hw/avalon_ram.sv
hw/mips_system.sv
tests/mips_system_tb.sv

/* Makefile */
# Verilator build and run for the MIPS system testbench.

VERILATOR ?= verilator
TOP       ?= mips_system_tb
FILELIST  ?= mips_system.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test failures found" $(LOG) || ! grep -q "All tests passed!" $(LOG); then \
		echo "FAIL"; \
		exit 1; \
	else \
		echo "PASS"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tests/mips_system_tb.sv */
`timescale 1ns/10ps

module mips_system_tb;
    import mips_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 5;
    localparam int MAX_PAIRS    = 12;
    localparam int NUM_ROWS     = 7;
    // Preload, five cycles per instruction at worst, reset and some slack.
    localparam int ROW_CYCLES   = MAX_PAIRS + 5 * MAX_PAIRS + RESET_CYCLES + 8;
    localparam int TIMEOUT_NS   = 2 * NUM_ROWS * ROW_CYCLES * CLK_PERIOD;

    // MIPS32 encodings of the supported instructions.
    localparam logic [5:0] OPC_SPECIAL = 6'h00;
    localparam logic [5:0] OPC_J       = 6'h02;
    localparam logic [5:0] OPC_ADDIU   = 6'h09;
    localparam logic [5:0] OPC_LW      = 6'h23;
    localparam logic [5:0] OPC_SW      = 6'h2b;
    localparam logic [5:0] FUNCT_JR    = 6'h08;
    localparam logic [5:0] FUNCT_ADDU  = 6'h21;

    localparam reg_idx_t R_ZERO = 5'd0;
    localparam reg_idx_t R_V0   = 5'd2;
    localparam reg_idx_t R_T0   = 5'd8;
    localparam reg_idx_t R_T1   = 5'd9;

    logic   clk;
    logic   arst_n;
    logic   load_en;
    addr_t  load_addr;
    word_t  load_data;
    logic   active;
    word_t  register_v0;
    integer seed;

    // Program table, one row per program.
    addr_t prog_addr  [NUM_ROWS][MAX_PAIRS];
    word_t prog_instr [NUM_ROWS][MAX_PAIRS];
    int    prog_len   [NUM_ROWS];
    word_t exp_v0     [NUM_ROWS];

    mips_system dut (
        .clk(clk), .arst_n(arst_n), .load_en(load_en), .load_addr(load_addr),
        .load_data(load_data), .active(active), .register_v0(register_v0)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Instruction encoders
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic word_t addiu(input reg_idx_t rt, input reg_idx_t rs,
                                    input logic [15:0] imm);
        return {OPC_ADDIU, rs, rt, imm};
    endfunction

    function automatic word_t addu(input reg_idx_t rd, input reg_idx_t rs,
                                   input reg_idx_t rt);
        return {OPC_SPECIAL, rs, rt, rd, 5'd0, FUNCT_ADDU};
    endfunction

    function automatic word_t load_word(input reg_idx_t rt, input reg_idx_t base,
                                        input logic [15:0] offset);
        return {OPC_LW, base, rt, offset};
    endfunction

    function automatic word_t store_word(input reg_idx_t rt, input reg_idx_t base,
                                         input logic [15:0] offset);
        return {OPC_SW, base, rt, offset};
    endfunction

    function automatic word_t jump(input addr_t target);
        return {OPC_J, target[27:2]};
    endfunction

    function automatic word_t jump_reg(input reg_idx_t rs);
        return {OPC_SPECIAL, rs, 5'd0, 5'd0, 5'd0, FUNCT_JR};
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1, "Simulation stopped.");
    endtask

    // Programs are stored from the reset vector upward.
    task automatic emit(input int row, input word_t instr);
        if (prog_len[row] >= MAX_PAIRS) begin
            abort_run("Program table row is longer than twelve instructions.");
        end
        prog_addr[row][prog_len[row]]  = 32'h0000_0004 + 4 * prog_len[row];
        prog_instr[row][prog_len[row]] = instr;
        prog_len[row]++;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Program table
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic build_table();
        word_t       rnd;
        logic [15:0] imm;
        for (int r = 0; r < NUM_ROWS; r++) begin
            prog_len[r] = 0;
            exp_v0[r]   = '0;
        end
        // Reference program. Delay slot runs, 0x10 and 0x20 are skipped.
        emit(0, addiu(R_V0, R_ZERO, 16'h0010));
        emit(0, jump(32'h0000_0014));
        emit(0, addiu(R_V0, R_V0, 16'h0080));
        emit(0, addiu(R_V0, R_V0, 16'h1000));
        emit(0, addiu(R_V0, R_V0, 16'h0010));
        emit(0, jump(32'h0000_0000));
        emit(0, addiu(R_ZERO, R_ZERO, 16'h0000));
        emit(0, addiu(R_V0, R_V0, 16'h0001));
        exp_v0[0] = 32'h0000_00a0;
        // Fixed immediates: 100 - 30 + 32767 - 32768.
        emit(1, addiu(R_V0, R_ZERO, 16'd100));
        emit(1, addiu(R_V0, R_V0, 16'hffe2));
        emit(1, addiu(R_V0, R_V0, 16'h7fff));
        emit(1, addiu(R_V0, R_V0, 16'h8000));
        emit(1, jump(32'h0000_0000));
        emit(1, addiu(R_ZERO, R_ZERO, 16'h0000));
        exp_v0[1] = 32'd69;
        // Random chains, the last addiu sits in the delay slot of j 0.
        for (int r = 2; r < 4; r++) begin
            for (int k = 0; k < 6; k++) begin
                rnd = $random(seed);
                imm = rnd[15:0];
                exp_v0[r] = exp_v0[r] + {{16{imm[15]}}, imm};
                if (k == 5) begin
                    emit(r, jump(32'h0000_0000));
                end
                emit(r, addiu(R_V0, (k == 0) ? R_ZERO : R_V0, imm));
            end
        end
        // Register zero ignores writes.
        emit(4, addiu(R_T0, R_ZERO, 16'h1234));
        emit(4, addu(R_ZERO, R_T0, R_T0));
        emit(4, addiu(R_T1, R_ZERO, 16'h0055));
        emit(4, addu(R_V0, R_ZERO, R_T1));
        emit(4, jump(32'h0000_0000));
        emit(4, addiu(R_ZERO, R_ZERO, 16'h0000));
        exp_v0[4] = 32'h0000_0055;
        // Store then load at 0x40 + 0x40.
        emit(5, addiu(R_T0, R_ZERO, 16'h0040));
        emit(5, addiu(R_T1, R_ZERO, 16'h8123));
        emit(5, store_word(R_T1, R_T0, 16'h0040));
        emit(5, load_word(R_V0, R_T0, 16'h0040));
        emit(5, jump(32'h0000_0000));
        emit(5, addiu(R_ZERO, R_ZERO, 16'h0000));
        exp_v0[5] = 32'hffff_8123;
        // jr through t0, which still holds zero from reset.
        emit(6, addiu(R_V0, R_ZERO, 16'd7));
        emit(6, jump_reg(R_T0));
        emit(6, addiu(R_V0, R_V0, 16'd9));
        emit(6, addiu(R_V0, R_V0, 16'h0100));
        exp_v0[6] = 32'd16;
    endtask

    // Reset, preload, run until active falls, then check v0.
    task automatic run_row(input int row);
        @(negedge clk);
        arst_n = 1'b0;
        for (int c = 0; c < RESET_CYCLES + prog_len[row]; c++) begin
            if (c >= RESET_CYCLES) begin
                load_en   = 1'b1;
                load_addr = prog_addr[row][c - RESET_CYCLES];
                load_data = prog_instr[row][c - RESET_CYCLES];
            end
            @(negedge clk);
            assert (active === 1'b0)
            else abort_run("Active was high while reset was asserted.");
        end
        load_en = 1'b0;
        arst_n  = 1'b1;
        @(negedge clk);
        assert (active === 1'b1)
        else abort_run("Active did not rise after reset was released.");
        while (active === 1'b1) begin
            @(negedge clk);
        end
        assert (register_v0 === exp_v0[row])
        else abort_run($sformatf("Error at %0d ns: register_v0 expected 0x%08h, got 0x%08h",
                                 $time, exp_v0[row], register_v0));
        $display("Program %0d halted with register_v0 = 0x%08h", row, register_v0);
    endtask

    initial begin
        clk       = 1'b0;
        arst_n    = 1'b0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        seed      = 32'h4d43_d2f4;
        build_table();
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end
        $display("All tests passed!");
        $finish;
    end

    // Watchdog.
    initial begin
        #(TIMEOUT_NS);
        abort_run("Timeout: the CPU never halted within the allowed time.");
    end

endmodule

/* hw/mips_system.sv */
`timescale 1ns/10ps

module mips_system (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            load_en,
    input  mips_pkg::addr_t load_addr,
    input  mips_pkg::word_t load_data,
    output logic            active,
    output mips_pkg::word_t register_v0
);
    import mips_pkg::*;

    avalon_req_t bus;
    logic        waitrequest;
    word_t       readdata;

    cpu_core u_cpu (
        .clk(clk), .arst_n(arst_n), .bus(bus), .waitrequest(waitrequest),
        .readdata(readdata), .active(active), .register_v0(register_v0)
    );

    avalon_ram u_ram (
        .clk(clk), .arst_n(arst_n), .bus(bus), .waitrequest(waitrequest),
        .readdata(readdata), .load_en(load_en), .load_addr(load_addr),
        .load_data(load_data)
    );

endmodule

/* hw/avalon_ram.sv */
`timescale 1ns/10ps

`include "mips_consts.svh"

module avalon_ram (
    input  logic                  clk,
    input  logic                  arst_n,
    input  mips_pkg::avalon_req_t bus,
    output logic                  waitrequest,
    output mips_pkg::word_t       readdata,
    input  logic                  load_en,
    input  mips_pkg::addr_t       load_addr,
    input  mips_pkg::word_t       load_data
);
    import mips_pkg::*;

    word_t                      mem [`MIPS_RAM_WORDS];
    logic                       wait_flag;
    logic                       access;
    logic [`MIPS_RAM_IDX_W-1:0] bus_idx;
    logic [`MIPS_RAM_IDX_W-1:0] load_idx;

    // Byte addresses, word storage.
    assign bus_idx  = bus.address[`MIPS_RAM_IDX_W+1:2];
    assign load_idx = load_addr[`MIPS_RAM_IDX_W+1:2];

    // First cycle of every access stalls, second one completes.
    assign access      = bus.read || bus.write;
    assign waitrequest = access && !wait_flag;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wait_flag <= 1'b0;
        end else begin
            wait_flag <= waitrequest;
        end
    end

    // Preload wins over the bus.
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_idx] <= load_data;
        end else if (bus.write && wait_flag) begin
            for (int b = 0; b < 4; b++) begin
                if (bus.byteenable[b]) begin
                    mem[bus_idx][8*b +: 8] <= bus.writedata[8*b +: 8];
                end
            end
        end
    end

    // Read data is captured during the wait cycle.
    always_ff @(posedge clk) begin
        if (bus.read && !wait_flag) begin
            readdata <= mem[bus_idx];
        end
    end

endmodule

/* hw/cpu/cpu_core.sv */
`timescale 1ns/10ps

module cpu_core (
    input  logic                  clk,
    input  logic                  arst_n,
    output mips_pkg::avalon_req_t bus,
    input  logic                  waitrequest,
    input  mips_pkg::word_t       readdata,
    output logic                  active,
    output mips_pkg::word_t       register_v0
);
    import mips_pkg::*;

    ctrl_state_t state;
    word_t       instr;
    decoded_t    dec;
    addr_t       pc;
    addr_t       mem_addr;
    addr_t       jump_target;
    word_t       rs_data;
    word_t       rt_data;
    word_t       result;
    logic        read;
    logic        write;
    logic        ir_load;
    logic        pc_step;
    logic        reg_we;
    logic        jump;
    logic        halt_req;

    // Instruction register.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            instr <= '0;
        end else if (ir_load) begin
            instr <= readdata;
        end
    end

    // Fetch uses the PC, data accesses use the computed address.
    always_comb begin
        bus.address    = (state == ctrl_mem_wait) ? mem_addr : pc;
        bus.write      = write;
        bus.read       = read;
        bus.writedata  = rt_data;
        bus.byteenable = 4'hf;
    end

    cpu_control u_control (
        .clk(clk), .arst_n(arst_n), .op(dec.op), .waitrequest(waitrequest),
        .halt_req(halt_req), .state(state), .read(read), .write(write),
        .ir_load(ir_load), .pc_step(pc_step), .reg_we(reg_we), .active(active)
    );

    pc_counter u_pc (
        .clk(clk), .arst_n(arst_n), .pc_step(pc_step), .jump(jump),
        .jump_target(jump_target), .pc(pc), .halt_req(halt_req)
    );

    reg_file u_regs (
        .clk(clk), .arst_n(arst_n), .rs(dec.rs), .rt(dec.rt), .rd(dec.rd),
        .we(reg_we), .wdata(result), .rs_data(rs_data), .rt_data(rt_data),
        .v0(register_v0)
    );

    alu_exec u_exec (
        .instr(instr), .pc(pc), .rs_data(rs_data), .rt_data(rt_data),
        .mem_rdata(readdata), .dec(dec), .result(result), .mem_addr(mem_addr),
        .jump(jump), .jump_target(jump_target)
    );

endmodule

/* hw/cpu/alu_exec.sv */
`timescale 1ns/10ps

`include "mips_consts.svh"

module alu_exec (
    input  mips_pkg::word_t    instr,
    input  mips_pkg::addr_t    pc,
    input  mips_pkg::word_t    rs_data,
    input  mips_pkg::word_t    rt_data,
    input  mips_pkg::word_t    mem_rdata,
    output mips_pkg::decoded_t dec,
    output mips_pkg::word_t    result,
    output mips_pkg::addr_t    mem_addr,
    output logic               jump,
    output mips_pkg::addr_t    jump_target
);
    import mips_pkg::*;

    word_t operand;
    word_t sum;
    addr_t pc_plus4;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        dec.rs    = instr[25:21];
        dec.rt    = instr[20:16];
        dec.rd    = instr[20:16];
        dec.imm   = {{16{instr[15]}}, instr[15:0]};
        dec.index = instr[25:0];
        dec.op    = op_illegal;
        case (instr[31:26])
            `MIPS_OPC_SPECIAL: begin
                if (instr[5:0] == `MIPS_FUNCT_ADDU) begin
                    dec.op = op_addu;
                    dec.rd = instr[15:11];
                end else if (instr[5:0] == `MIPS_FUNCT_JR) begin
                    dec.op = op_jr;
                end
            end
            `MIPS_OPC_ADDIU: dec.op = op_addiu;
            `MIPS_OPC_LW:    dec.op = op_lw;
            `MIPS_OPC_SW:    dec.op = op_sw;
            `MIPS_OPC_J:     dec.op = op_j;
            default:         dec.op = op_illegal;
        endcase
    end

    // One adder serves addiu, addu and load/store addressing.
    assign operand  = (dec.op == op_addu) ? rt_data : dec.imm;
    assign sum      = rs_data + operand;
    assign mem_addr = sum;
    assign result   = (dec.op == op_lw) ? mem_rdata : sum;

    // j keeps the top bits of the delay-slot address.
    assign pc_plus4    = pc + 32'd4;
    assign jump        = (dec.op == op_j) || (dec.op == op_jr);
    assign jump_target = (dec.op == op_jr) ? rs_data
                                           : {pc_plus4[31:28], dec.index, 2'b00};

endmodule

/* hw/cpu/reg_file.sv */
`timescale 1ns/10ps

`include "mips_consts.svh"

module reg_file (
    input  logic               clk,
    input  logic               arst_n,
    input  mips_pkg::reg_idx_t rs,
    input  mips_pkg::reg_idx_t rt,
    input  mips_pkg::reg_idx_t rd,
    input  logic               we,
    input  mips_pkg::word_t    wdata,
    output mips_pkg::word_t    rs_data,
    output mips_pkg::word_t    rt_data,
    output mips_pkg::word_t    v0
);
    import mips_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd != 5'd0)) begin
            regs[rd] <= wdata;
        end
    end

    // Register zero is never written and keeps reading as zero.
    assign rs_data = regs[rs];
    assign rt_data = regs[rt];
    assign v0      = regs[`MIPS_REG_V0];

endmodule

/* hw/cpu/pc_counter.sv */
`timescale 1ns/10ps

`include "mips_consts.svh"

module pc_counter (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            pc_step,
    input  logic            jump,
    input  mips_pkg::addr_t jump_target,
    output mips_pkg::addr_t pc,
    output logic            halt_req
);
    import mips_pkg::*;

    // Address of the instruction after the current one, which is
    // the jump target while a delay slot is running.
    addr_t npc;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc       <= `MIPS_RESET_VECTOR;
            npc      <= `MIPS_RESET_VECTOR + 32'd4;
            halt_req <= 1'b0;
        end else if (pc_step) begin
            pc <= npc;
            // PC plus eight in straight-line code.
            if (jump) begin
                npc <= jump_target;
            end else begin
                npc <= npc + 32'd4;
            end
            // Jump to zero means the program is finished.
            if (jump && (jump_target == '0)) begin
                halt_req <= 1'b1;
            end
        end
    end

endmodule

/* hw/cpu/cpu_control.sv */
`timescale 1ns/10ps

module cpu_control (
    input  logic                  clk,
    input  logic                  arst_n,
    input  mips_pkg::opcode_t     op,
    input  logic                  waitrequest,
    input  logic                  halt_req,
    output mips_pkg::ctrl_state_t state,
    output logic                  read,
    output logic                  write,
    output logic                  ir_load,
    output logic                  pc_step,
    output logic                  reg_we,
    output logic                  active
);
    import mips_pkg::*;

    ctrl_state_t state_d;
    logic        is_mem;

    assign is_mem = (op == op_lw) || (op == op_sw);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Next state and strobes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        state_d = state;
        read    = 1'b0;
        write   = 1'b0;
        ir_load = 1'b0;
        pc_step = 1'b0;
        reg_we  = 1'b0;
        case (state)
            ctrl_fetch, ctrl_fetch_wait: begin
                read = 1'b1;
                if (!waitrequest) begin
                    ir_load = 1'b1;
                    state_d = ctrl_execute;
                end else begin
                    state_d = ctrl_fetch_wait;
                end
            end
            ctrl_execute: begin
                if (is_mem) begin
                    state_d = ctrl_mem_wait;
                end else begin
                    pc_step = 1'b1;
                    reg_we  = (op == op_addiu) || (op == op_addu);
                    state_d = halt_req ? ctrl_halted : ctrl_fetch;
                end
            end
            ctrl_mem_wait: begin
                // Bus request held until the slave lets go.
                read  = (op == op_lw);
                write = (op == op_sw);
                if (!waitrequest) begin
                    pc_step = 1'b1;
                    reg_we  = (op == op_lw);
                    state_d = halt_req ? ctrl_halted : ctrl_fetch;
                end
            end
            default: state_d = ctrl_halted;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= ctrl_fetch;
            active <= 1'b0;
        end else begin
            state  <= state_d;
            active <= (state_d != ctrl_halted);
        end
    end

endmodule

/* common/mips_pkg.sv */
package mips_pkg;

    // Basic widths.
    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [4:0]  reg_idx_t;

    // Supported operations, anything else decodes to op_illegal.
    typedef enum logic [2:0] {
        op_addiu,
        op_addu,
        op_lw,
        op_sw,
        op_j,
        op_jr,
        op_illegal
    } opcode_t;

    typedef struct packed {
        opcode_t     op;
        reg_idx_t    rs;
        reg_idx_t    rt;
        reg_idx_t    rd;
        word_t       imm;
        logic [25:0] index;
    } decoded_t;

    // Avalon master request, driven by the core.
    typedef struct packed {
        addr_t       address;
        logic        write;
        logic        read;
        word_t       writedata;
        logic [3:0]  byteenable;
    } avalon_req_t;

    typedef enum logic [2:0] {
        ctrl_fetch,
        ctrl_fetch_wait,
        ctrl_execute,
        ctrl_mem_wait,
        ctrl_halted
    } ctrl_state_t;

endpackage

/* common/mips_consts.svh */
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

// First instruction fetched after reset.
`define MIPS_RESET_VECTOR 32'h0000_0004

// RAM geometry, in 32-bit words.
`define MIPS_RAM_WORDS    256
`define MIPS_RAM_IDX_W    8

// Primary opcodes.
`define MIPS_OPC_SPECIAL  6'h00
`define MIPS_OPC_J        6'h02
`define MIPS_OPC_ADDIU    6'h09
`define MIPS_OPC_LW       6'h23
`define MIPS_OPC_SW       6'h2b

// Funct codes under SPECIAL.
`define MIPS_FUNCT_JR     6'h08
`define MIPS_FUNCT_ADDU   6'h21

`define MIPS_REG_V0       5'd2

`endif
